// File: gbe_rx_defines.svh
`ifndef GBE_RX_DEFINES_SVH
`define GBE_RX_DEFINES_SVH

// section lengths in bytes
`define GBE_MAC_HDR_LEN      14
`define GBE_IP_HDR_LEN       20
`define GBE_UDP_HDR_LEN      8

// field offsets, counted from the start of their own section
`define GBE_ETH_DST_OFS      0
`define GBE_MAC_ADDR_LEN     6
`define GBE_ETH_TYPE_OFS     12
`define GBE_IP_VER_OFS       0
`define GBE_IP_PROTO_OFS     9
`define GBE_IP_SRC_OFS       12
`define GBE_IP_DST_OFS       16
`define GBE_UDP_SRC_OFS      0
`define GBE_UDP_DST_OFS      2

// match values
`define GBE_ETHERTYPE_IPV4   16'h0800
`define GBE_IP_VER_IHL       8'h45
`define GBE_IP_PROTO_UDP     8'h11

`define GBE_PKT_FIFO_DEPTH   2048
`define GBE_CTRL_FIFO_DEPTH  32

`endif

// File: gbe_frame_pkg.sv
`default_nettype none

package gbe_frame_pkg;

  // one payload byte as stored in the packet FIFO
  typedef struct packed {
    logic [7:0] data;
    // last byte of the frame
    logic       eof;
    // MAC flagged the frame as bad, only valid together with eof
    logic       bad;
  } pkt_word_t;

  // per-frame sender information, one entry per accepted frame
  typedef struct packed {
    logic [31:0] src_ip;
    logic [15:0] src_port;
  } ctrl_word_t;

endpackage

`default_nettype wire

// File: gbe_rx_ctrl_pkg.sv
`default_nettype none

package gbe_rx_ctrl_pkg;

  // position of the header walk within a frame
  typedef enum logic [2:0] {
    HDR_IDLE = 3'd0,
    HDR_ETH  = 3'd1,
    HDR_IP   = 3'd2,
    HDR_UDP  = 3'd3,
    HDR_DATA = 3'd4
  } hdr_state_t;

  // whether the writer may start putting frames into the FIFOs
  typedef enum logic {
    ADMIT_RUN     = 1'b0,
    ADMIT_BLOCKED = 1'b1
  } admit_state_t;

endpackage

`default_nettype wire

// File: hdr_byte_counter.sv
`default_nettype none

module hdr_byte_counter (
  input  logic       mac_clk,
  input  logic       mac_rst,
  input  logic       cnt_clr,
  output logic [5:0] byte_idx
);

  // position of the current byte inside its header section
  // cleared on the same edge that moves the fsm into a new section
  always_ff @(posedge mac_clk) begin
    if (mac_rst || cnt_clr) begin
      byte_idx <= 6'd0;
    end else begin
      // free running in the payload, the value is ignored there
      byte_idx <= byte_idx + 6'd1;
    end
  end

endmodule

`default_nettype wire

// File: rx_hdr_fsm.sv
`default_nettype none

`include "gbe_rx_defines.svh"

module rx_hdr_fsm (
  input  logic                        mac_clk,
  input  logic                        mac_rst,
  input  logic                        mac_rx_dvld,
  input  logic [5:0]                  byte_idx,
  output logic                        cnt_clr,
  output gbe_rx_ctrl_pkg::hdr_state_t hdr_state
);

  import gbe_rx_ctrl_pkg::*;

  hdr_state_t state_nxt;

  // hdr_state lags the MAC input by one register, so in a header state
  // mac_rx_dvld already tells whether another byte follows
  always_comb begin
    state_nxt = hdr_state;
    cnt_clr   = 1'b0;
    case (hdr_state)
      HDR_IDLE: begin
        if (mac_rx_dvld) begin
          state_nxt = HDR_ETH;
          cnt_clr   = 1'b1;
        end
      end
      HDR_ETH: begin
        if (byte_idx == 6'(`GBE_MAC_HDR_LEN - 1)) begin
          state_nxt = HDR_IP;
          cnt_clr   = 1'b1;
        end
      end
      HDR_IP: begin
        if (byte_idx == 6'(`GBE_IP_HDR_LEN - 1)) begin
          state_nxt = HDR_UDP;
          cnt_clr   = 1'b1;
        end
      end
      HDR_UDP: begin
        if (byte_idx == 6'(`GBE_UDP_HDR_LEN - 1)) begin
          state_nxt = HDR_DATA;
          cnt_clr   = 1'b1;
        end
      end
      HDR_DATA: begin
        if (!mac_rx_dvld) begin
          state_nxt = HDR_IDLE;
        end
      end
      default: begin
        state_nxt = HDR_IDLE;
      end
    endcase
    // runt frame, the header was cut short or there is no payload
    if (hdr_state != HDR_IDLE && !mac_rx_dvld) begin
      state_nxt = HDR_IDLE;
      cnt_clr   = 1'b0;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      hdr_state <= HDR_IDLE;
    end else begin
      hdr_state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdr_filter.sv
`default_nettype none

`include "gbe_rx_defines.svh"

module hdr_filter (
  input  logic                        mac_clk,
  input  logic                        mac_rst,
  input  gbe_rx_ctrl_pkg::hdr_state_t hdr_state,
  input  logic [5:0]                  byte_idx,
  input  logic [7:0]                  hdr_byte,
  input  logic                        local_enable,
  input  logic [47:0]                 local_mac,
  input  logic [31:0]                 local_ip,
  input  logic [15:0]                 local_port,
  output logic                        frame_ok,
  output gbe_frame_pkg::ctrl_word_t   ctrl_info
);

  import gbe_rx_ctrl_pkg::*;

  localparam logic [15:0] ETHERTYPE_C = `GBE_ETHERTYPE_IPV4;

  logic [5:0]  mac_pos;
  logic [5:0]  type_pos;
  logic [5:0]  ip_pos;
  logic [5:0]  port_pos;
  logic [5:0]  sip_pos;
  logic [5:0]  sport_pos;
  logic [47:0] mac_shift;
  logic [15:0] type_shift;
  logic [31:0] ip_shift;
  logic [15:0] port_shift;
  logic        byte_ok;
  logic        chk_ok;
  logic        en_r;
  logic        en_rr;
  hdr_state_t  state_r;

  // byte position relative to each field, wraps to large values before it
  assign mac_pos   = byte_idx - 6'(`GBE_ETH_DST_OFS);
  assign type_pos  = byte_idx - 6'(`GBE_ETH_TYPE_OFS);
  assign ip_pos    = byte_idx - 6'(`GBE_IP_DST_OFS);
  assign port_pos  = byte_idx - 6'(`GBE_UDP_DST_OFS);
  assign sip_pos   = byte_idx - 6'(`GBE_IP_SRC_OFS);
  assign sport_pos = byte_idx - 6'(`GBE_UDP_SRC_OFS);

  // expected byte sits in bits [7:0], fields go out MSB first
  assign mac_shift  = local_mac >> {3'(`GBE_MAC_ADDR_LEN - 1) - mac_pos[2:0], 3'b000};
  assign type_shift = ETHERTYPE_C >> {~type_pos[0], 3'b000};
  assign ip_shift   = local_ip >> {2'd3 - ip_pos[1:0], 3'b000};
  assign port_shift = local_port >> {~port_pos[0], 3'b000};

  always_comb begin
    byte_ok = 1'b1;
    case (hdr_state)
      HDR_ETH: begin
        // broadcast bytes pass on their own
        if (mac_pos < 6'(`GBE_MAC_ADDR_LEN)) begin
          byte_ok = (hdr_byte == mac_shift[7:0]) || (hdr_byte == 8'hff);
        end else if (type_pos < 6'd2) begin
          byte_ok = hdr_byte == type_shift[7:0];
        end
      end
      HDR_IP: begin
        if (byte_idx == 6'(`GBE_IP_VER_OFS)) begin
          byte_ok = hdr_byte == `GBE_IP_VER_IHL;
        end else if (byte_idx == 6'(`GBE_IP_PROTO_OFS)) begin
          byte_ok = hdr_byte == `GBE_IP_PROTO_UDP;
        end else if (ip_pos < 6'd4) begin
          byte_ok = hdr_byte == ip_shift[7:0];
        end
      end
      HDR_UDP: begin
        if (port_pos < 6'd2) begin
          byte_ok = hdr_byte == port_shift[7:0];
        end
      end
      default: begin
        byte_ok = 1'b1;
      end
    endcase
  end

  // enable crosses in from outside the receive path, retime it
  always_ff @(posedge mac_clk) begin
    en_r  <= local_enable;
    en_rr <= en_r;
  end

  // one register stage on the checks, the state travels with them
  always_ff @(posedge mac_clk) begin
    chk_ok <= en_rr && byte_ok;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state_r  <= HDR_IDLE;
      frame_ok <= 1'b1;
    end else begin
      state_r <= hdr_state;
      case (state_r)
        HDR_IDLE: frame_ok <= 1'b1;
        HDR_ETH, HDR_IP, HDR_UDP: frame_ok <= frame_ok && chk_ok;
        default: frame_ok <= frame_ok;
      endcase
    end
  end

  // sender fields shift in MSB first
  always_ff @(posedge mac_clk) begin
    if (hdr_state == HDR_IP && sip_pos < 6'd4) begin
      ctrl_info.src_ip <= {ctrl_info.src_ip[23:0], hdr_byte};
    end
    if (hdr_state == HDR_UDP && sport_pos < 6'd2) begin
      ctrl_info.src_port <= {ctrl_info.src_port[7:0], hdr_byte};
    end
  end

endmodule

`default_nettype wire

// File: rx_fifo.sv
`default_nettype none

module rx_fifo #(
  parameter type payload_t = logic [7:0],
  // must be a power of two
  parameter int  DEPTH     = 16
) (
  input  logic     mac_clk,
  input  logic     mac_rst,
  input  payload_t din,
  input  logic     wr_en,
  input  logic     rd_en,
  output payload_t dout,
  output logic     empty,
  output logic     overflow
);

  localparam int AW = $clog2(DEPTH);

  payload_t    mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  // extra pointer bit tells full from empty
  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // show-ahead, the head entry is visible without a read
  assign dout = empty ? '0 : mem[rd_ptr[AW-1:0]];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= din;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // the word is dropped
      overflow <= wr_en && full;
    end
  end

endmodule

`default_nettype wire

// File: app_packet_writer.sv
`default_nettype none

module app_packet_writer (
  input  logic                        mac_clk,
  input  logic                        mac_rst,
  input  logic [7:0]                  mac_rx_data,
  input  logic                        mac_rx_dvld,
  input  logic                        mac_rx_badframe,
  input  logic                        overrun_clr,
  input  gbe_rx_ctrl_pkg::hdr_state_t hdr_state,
  input  logic                        frame_ok,
  input  gbe_frame_pkg::ctrl_word_t   ctrl_info,
  input  logic                        pkt_overflow,
  input  logic                        ctrl_overflow,
  output logic [7:0]                  hdr_byte,
  output gbe_frame_pkg::pkt_word_t    pkt_din,
  output logic                        pkt_wr,
  output gbe_frame_pkg::ctrl_word_t   ctrl_din,
  output logic                        ctrl_wr,
  output logic                        app_overrun
);

  import gbe_rx_ctrl_pkg::*;

  logic         hdr_dvld;
  logic [7:0]   data_a;
  logic         dvld_a;
  logic         bad_r;
  logic         pay_vld;
  logic         pay_first;
  logic         eof;
  logic         admit;
  logic         rx_overrun;
  admit_state_t admit_state;

  // stage 1 feeds the header walk, stage 2 waits for the verdict
  always_ff @(posedge mac_clk) begin
    hdr_byte <= mac_rx_data;
    data_a   <= hdr_byte;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      hdr_dvld  <= 1'b0;
      dvld_a    <= 1'b0;
      bad_r     <= 1'b0;
      pay_vld   <= 1'b0;
      pay_first <= 1'b0;
    end else begin
      hdr_dvld  <= mac_rx_dvld;
      dvld_a    <= hdr_dvld;
      // strobe follows the last byte by one cycle, lands next to it in stage 2
      bad_r     <= mac_rx_badframe;
      pay_vld   <= hdr_state == HDR_DATA;
      pay_first <= (hdr_state == HDR_DATA) && !pay_vld;
    end
  end

  // last byte sits in stage 2 while stage 1 is already empty
  assign eof = dvld_a && !hdr_dvld;

  // sticky until cleared, a new overflow wins over the clear
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      rx_overrun <= 1'b0;
    end else if (pkt_overflow || ctrl_overflow) begin
      rx_overrun <= 1'b1;
    end else if (overrun_clr) begin
      rx_overrun <= 1'b0;
    end
  end

  assign app_overrun = rx_overrun;

  // only resume between frames
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      admit_state <= ADMIT_RUN;
    end else begin
      case (admit_state)
        ADMIT_RUN: begin
          if (rx_overrun) begin
            admit_state <= ADMIT_BLOCKED;
          end
        end
        ADMIT_BLOCKED: begin
          if (!rx_overrun && !dvld_a) begin
            admit_state <= ADMIT_RUN;
          end
        end
        default: admit_state <= ADMIT_RUN;
      endcase
    end
  end

  assign admit = (admit_state == ADMIT_RUN) && frame_ok && dvld_a;

  assign pkt_din = '{data: data_a, eof: eof, bad: eof && bad_r};
  assign pkt_wr  = pay_vld && admit;

  assign ctrl_din = ctrl_info;
  assign ctrl_wr  = pay_first && admit;

endmodule

`default_nettype wire

// File: gbe_rx.sv
`default_nettype none

`include "gbe_rx_defines.svh"

module gbe_rx (
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  logic [7:0]  mac_rx_data,
  input  logic        mac_rx_dvld,
  input  logic        mac_rx_goodframe,
  input  logic        mac_rx_badframe,
  input  logic        local_enable,
  input  logic [47:0] local_mac,
  input  logic [31:0] local_ip,
  input  logic [15:0] local_port,
  input  logic        app_ack,
  input  logic        overrun_clr,
  output logic [7:0]  app_data,
  output logic        app_dvld,
  output logic        app_eof,
  output logic        app_badframe,
  output logic [31:0] app_srcip,
  output logic [15:0] app_srcport,
  output logic        app_overrun
);

  import gbe_frame_pkg::*;
  import gbe_rx_ctrl_pkg::*;

  logic [5:0] byte_idx;
  logic       cnt_clr;
  hdr_state_t hdr_state;
  logic [7:0] hdr_byte;
  logic       frame_ok;
  ctrl_word_t ctrl_info;
  pkt_word_t  pkt_din;
  pkt_word_t  pkt_dout;
  logic       pkt_wr;
  logic       pkt_empty;
  logic       pkt_overflow;
  ctrl_word_t ctrl_din;
  ctrl_word_t ctrl_dout;
  logic       ctrl_wr;
  logic       ctrl_rd;
  logic       ctrl_empty;
  logic       ctrl_overflow;

  hdr_byte_counter cnt_i (
    .mac_clk  (mac_clk),
    .mac_rst  (mac_rst),
    .cnt_clr  (cnt_clr),
    .byte_idx (byte_idx)
  );

  rx_hdr_fsm fsm_i (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .mac_rx_dvld (mac_rx_dvld),
    .byte_idx    (byte_idx),
    .cnt_clr     (cnt_clr),
    .hdr_state   (hdr_state)
  );

  hdr_filter filter_i (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .hdr_state    (hdr_state),
    .byte_idx     (byte_idx),
    .hdr_byte     (hdr_byte),
    .local_enable (local_enable),
    .local_mac    (local_mac),
    .local_ip     (local_ip),
    .local_port   (local_port),
    .frame_ok     (frame_ok),
    .ctrl_info    (ctrl_info)
  );

  app_packet_writer writer_i (
    .mac_clk         (mac_clk),
    .mac_rst         (mac_rst),
    .mac_rx_data     (mac_rx_data),
    .mac_rx_dvld     (mac_rx_dvld),
    .mac_rx_badframe (mac_rx_badframe),
    .overrun_clr     (overrun_clr),
    .hdr_state       (hdr_state),
    .frame_ok        (frame_ok),
    .ctrl_info       (ctrl_info),
    .pkt_overflow    (pkt_overflow),
    .ctrl_overflow   (ctrl_overflow),
    .hdr_byte        (hdr_byte),
    .pkt_din         (pkt_din),
    .pkt_wr          (pkt_wr),
    .ctrl_din        (ctrl_din),
    .ctrl_wr         (ctrl_wr),
    .app_overrun     (app_overrun)
  );

  rx_fifo #(
    .payload_t (pkt_word_t),
    .DEPTH     (`GBE_PKT_FIFO_DEPTH)
  ) pkt_fifo_i (
    .mac_clk  (mac_clk),
    .mac_rst  (mac_rst),
    .din      (pkt_din),
    .wr_en    (pkt_wr),
    .rd_en    (app_ack),
    .dout     (pkt_dout),
    .empty    (pkt_empty),
    .overflow (pkt_overflow)
  );

  rx_fifo #(
    .payload_t (ctrl_word_t),
    .DEPTH     (`GBE_CTRL_FIFO_DEPTH)
  ) ctrl_fifo_i (
    .mac_clk  (mac_clk),
    .mac_rst  (mac_rst),
    .din      (ctrl_din),
    .wr_en    (ctrl_wr),
    .rd_en    (ctrl_rd),
    .dout     (ctrl_dout),
    .empty    (ctrl_empty),
    .overflow (ctrl_overflow)
  );

  // app side reads straight from the FIFO heads
  assign app_dvld     = !pkt_empty;
  assign app_data     = pkt_dout.data;
  assign app_eof      = pkt_dout.eof;
  assign app_badframe = pkt_dout.bad;
  assign app_srcip    = ctrl_dout.src_ip;
  assign app_srcport  = ctrl_dout.src_port;

  // control entry retires together with the last byte of its frame
  assign ctrl_rd = app_ack && app_eof && app_dvld && !ctrl_empty;

endmodule

`default_nettype wire

// File: tb_gbe_rx_sva.sv
`default_nettype none

module tb_gbe_rx_sva (
  input logic                          mac_clk,
  input logic                          mac_rst,
  input logic                          pkt_wr,
  input gbe_rx_ctrl_pkg::admit_state_t admit_state,
  input logic                          app_eof,
  input logic                          app_dvld,
  input logic                          app_overrun
);

  import gbe_rx_ctrl_pkg::*;

  // a flagged overrun blocks the writer from the next edge on
  no_write_blocked: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_overrun |=> admit_state == ADMIT_BLOCKED && !pkt_wr)
    else $error("packet write while admission blocked");

  eof_needs_dvld: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_eof |-> app_dvld)
    else $error("app_eof without app_dvld");

  overrun_low_after_rst: assert property (@(posedge mac_clk) mac_rst |=> !app_overrun)
    else $error("app_overrun high after reset");

endmodule

bind gbe_rx tb_gbe_rx_sva sva_i (
  .mac_clk     (mac_clk),
  .mac_rst     (mac_rst),
  .pkt_wr      (pkt_wr),
  .admit_state (writer_i.admit_state),
  .app_eof     (app_eof),
  .app_dvld    (app_dvld),
  .app_overrun (app_overrun)
);

`default_nettype wire

// File: tb_gbe_rx.sv
`default_nettype none

`include "gbe_rx_defines.svh"

module tb_gbe_rx;

  // upper bound on the number of frames sent in all tests
  localparam int MAX_FRAMES  = 100;
  // cycles for the headers, the largest payload and the gap after a frame
  localparam int FRAME_CYC   = `GBE_MAC_HDR_LEN + `GBE_IP_HDR_LEN + `GBE_UDP_HDR_LEN + 16 + 5;
  localparam int LIMIT_CYC   = MAX_FRAMES * FRAME_CYC * 4 + 5000;
  localparam logic [47:0] MY_MAC  = 48'h02_00_5e_10_20_30;
  localparam logic [31:0] MY_IP   = 32'hc0a8_0114;
  localparam logic [15:0] MY_PORT = 16'h1f90;

  logic mac_clk;
  logic mac_rst;
  logic mac_rx_dvld;
  logic mac_rx_goodframe;
  logic mac_rx_badframe;
  logic [7:0] mac_rx_data;
  logic local_enable;
  logic app_ack;
  logic overrun_clr;
  logic [7:0] app_data;
  logic app_dvld;
  logic app_eof;
  logic app_badframe;
  logic app_overrun;
  logic [31:0] app_srcip;
  logic [15:0] app_srcport;

  // expected entry {data, eof, bad, src_ip, src_port}
  logic [57:0] exp_q[$];
  logic [57:0] exp_w;
  int cycle_cnt;
  int ack_mode;
  bit checking;

  gbe_rx dut_i (.*, .local_mac(MY_MAC), .local_ip(MY_IP), .local_port(MY_PORT));

  always #5 mac_clk = ~mac_clk;

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1);
  endtask

  // acceptance rules of the filter
  function automatic bit frame_accepted(input logic [47:0] dmac, input logic [15:0] etype,
                                        input logic [7:0] verihl, input logic [7:0] proto,
                                        input logic [31:0] dip, input logic [15:0] dport,
                                        input logic en);
    bit ok;
    ok = en && etype == `GBE_ETHERTYPE_IPV4 && verihl == `GBE_IP_VER_IHL;
    ok = ok && proto == `GBE_IP_PROTO_UDP && dip == MY_IP && dport == MY_PORT;
    for (int i = 0; i < 6; i++) begin
      if (dmac[8*i +: 8] != MY_MAC[8*i +: 8] && dmac[8*i +: 8] != 8'hff) ok = 0;
    end
    return ok;
  endfunction

  task automatic send_frame(input logic [47:0] dmac, input logic [15:0] etype,
                            input logic [7:0] verihl, input logic [7:0] proto,
                            input logic [31:0] dip, input logic [15:0] dport,
                            input bit bad, input int plen, input bit record);
    logic [7:0] fr[$];
    logic [31:0] sip;
    logic [15:0] sport;
    logic [7:0] pb;
    bit acc;
    sip = $urandom;
    sport = 16'($urandom);
    acc = record && frame_accepted(dmac, etype, verihl, proto, dip, dport, local_enable);
    for (int i = 5; i >= 0; i--) fr.push_back(dmac[8*i +: 8]);
    for (int i = 0; i < 6; i++) fr.push_back(8'h10 + 8'(i));
    fr.push_back(etype[15:8]);
    fr.push_back(etype[7:0]);
    fr.push_back(verihl);
    for (int i = 1; i < 9; i++) fr.push_back(8'h00);
    fr.push_back(proto);
    fr.push_back(8'h00);
    fr.push_back(8'h00);
    for (int i = 3; i >= 0; i--) fr.push_back(sip[8*i +: 8]);
    for (int i = 3; i >= 0; i--) fr.push_back(dip[8*i +: 8]);
    fr.push_back(sport[15:8]);
    fr.push_back(sport[7:0]);
    fr.push_back(dport[15:8]);
    fr.push_back(dport[7:0]);
    for (int i = 0; i < 4; i++) fr.push_back(8'h00);
    for (int i = 0; i < plen; i++) begin
      pb = 8'($urandom);
      fr.push_back(pb);
      if (acc) exp_q.push_back({pb, i == plen - 1, bad && i == plen - 1, sip, sport});
    end
    foreach (fr[i]) begin
      @(posedge mac_clk);
      #1;
      mac_rx_dvld = 1'b1;
      mac_rx_data = fr[i];
    end
    @(posedge mac_clk);
    #1;
    mac_rx_dvld = 1'b0;
    mac_rx_goodframe = !bad;
    mac_rx_badframe = bad;
    @(posedge mac_clk);
    #1;
    mac_rx_goodframe = 1'b0;
    mac_rx_badframe = 1'b0;
    repeat (3) @(posedge mac_clk);
  endtask

  // kinds 0 and 1 match and kind 2 is broadcast
  // kinds 3 to 8 each carry one wrong field
  task automatic send_kind(input int kind, input bit bad, input int plen, input bit record);
    send_frame(kind == 2 ? 48'hffff_ffff_ffff : (kind == 3 ? MY_MAC ^ 48'h1 : MY_MAC),
               kind == 4 ? 16'h86dd : `GBE_ETHERTYPE_IPV4,
               kind == 5 ? 8'h46 : `GBE_IP_VER_IHL,
               kind == 6 ? 8'h06 : `GBE_IP_PROTO_UDP, kind == 7 ? MY_IP ^ 32'h1 : MY_IP,
               kind == 8 ? MY_PORT ^ 16'h1 : MY_PORT, bad, plen, record);
  endtask

  task automatic wait_drained();
    repeat (10) @(posedge mac_clk);
    while (exp_q.size() != 0 || app_dvld) @(posedge mac_clk);
  endtask

  always @(posedge mac_clk) begin
    #1;
    app_ack = ack_mode == 1 ? 1'b1 : (ack_mode == 2 ? ($urandom % 3 != 0) : 1'b0);
  end

  // one expected entry per popped byte
  always @(posedge mac_clk) begin
    if (!mac_rst && checking && app_ack && app_dvld) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("unexpected byte delivered at time %0t", $time));
      end else begin
        exp_w = exp_q.pop_front();
        assert (app_data == exp_w[57:50] && app_eof == exp_w[49] && app_badframe == exp_w[48])
        else fail_run($sformatf("CHECK FAILED at %0t: data/eof/bad %h/%b/%b, expected %h/%b/%b",
                                $time, app_data, app_eof, app_badframe,
                                exp_w[57:50], exp_w[49], exp_w[48]));
        assert (app_srcip == exp_w[47:16] && app_srcport == exp_w[15:0])
        else fail_run($sformatf("CHECK FAILED at %0t: source %h:%h, expected %h:%h", $time,
                                app_srcip, app_srcport, exp_w[47:16], exp_w[15:0]));
      end
    end
  end

  always @(posedge mac_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT_CYC) fail_run("simulation timed out waiting for the DUT");
  end

  initial begin
    void'($urandom(44747));
    mac_clk = 0;
    mac_rst = 1;
    mac_rx_dvld = 0;
    mac_rx_data = 0;
    mac_rx_goodframe = 0;
    mac_rx_badframe = 0;
    local_enable = 1;
    app_ack = 0;
    overrun_clr = 0;
    cycle_cnt = 0;
    ack_mode = 1;
    checking = 1;
    repeat (5) @(posedge mac_clk);
    #1 mac_rst = 0;
    repeat (5) @(posedge mac_clk);
    for (int k = 0; k < 4; k++) send_kind(k % 3, 0, 6 + k, 1);
    wait_drained();
    for (int k = 3; k < 9; k++) begin
      send_kind(k, 0, 8, 1);
      send_kind(0, 0, 5, 1);
    end
    wait_drained();
    #1 local_enable = 0;
    repeat (5) @(posedge mac_clk);
    send_kind(0, 0, 7, 1);
    send_kind(2, 0, 7, 1);
    #1 local_enable = 1;
    repeat (5) @(posedge mac_clk);
    send_kind(1, 0, 9, 1);
    send_kind(0, 1, 10, 1);
    send_kind(0, 0, 4, 1);
    wait_drained();
    // one frame more than the control FIFO holds
    ack_mode = 0;
    repeat (3) @(posedge mac_clk);
    for (int k = 0; k <= `GBE_CTRL_FIFO_DEPTH; k++) send_kind(0, 0, 8, 0);
    repeat (10) @(posedge mac_clk);
    assert (app_overrun) else fail_run($sformatf("CHECK FAILED at %0t: no overrun", $time));
    #1 overrun_clr = 1;
    @(posedge mac_clk);
    #1 overrun_clr = 0;
    @(posedge mac_clk);
    checking = 0;
    ack_mode = 1;
    repeat (3) @(posedge mac_clk);
    while (app_dvld) @(posedge mac_clk);
    #2 checking = 1;
    assert (!app_overrun) else fail_run($sformatf("CHECK FAILED at %0t: overrun stuck", $time));
    send_kind(0, 0, 12, 1);
    wait_drained();
    ack_mode = 2;
    for (int k = 0; k < 40; k++) begin
      send_kind($urandom % 9, $urandom % 5 == 0, 1 + $urandom % 16, 1);
    end
    ack_mode = 1;
    wait_drained();
    if (exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run("expected bytes were never delivered");
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
gbe_frame_pkg.sv
gbe_rx_ctrl_pkg.sv
hdr_byte_counter.sv
rx_hdr_fsm.sv
hdr_filter.sv
rx_fifo.sv
app_packet_writer.sv
gbe_rx.sv
tb_gbe_rx_sva.sv
tb_gbe_rx.sv

// File: Makefile
TOP = tb_gbe_rx

all: run

obj_dir/V$(TOP): src.f $(wildcard *.sv *.svh)
	verilator --binary --assert -Wno-fatal -I. -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --assert -I. -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
